// File: hdl/tetris_score_pkg.sv
package tetris_score_pkg;

  // ====================================================================
  // Event and request types
  // ====================================================================
  typedef enum logic [2:0] {
    SPIN_NONE,
    SPIN_T,
    SPIN_T_MINI,
    SPIN_SZ,
    SPIN_JL,
    SPIN_I
  } spin_kind_e;

  localparam int SCORE_DIGITS = 8;
  localparam int AWARD_DIGITS = 5;

  typedef logic [7:0]                   line_count_t;
  typedef logic [3:0]                   level_t;
  typedef logic [5:0]                   frames_t;  // Gravity frames per drop
  typedef logic [3:0]                   streak_t;
  typedef logic [15:0]                  points_t;
  typedef logic [AWARD_DIGITS-1:0][3:0] bcd_award_t;  // Digit 0 is the ones digit
  typedef logic [SCORE_DIGITS-1:0][3:0] score_bcd_t;

  typedef struct packed {
    logic [2:0] lines;  // 0 to 4
    spin_kind_e spin;
  } clear_event_t;

  typedef struct packed {
    logic [2:0] lines;
    spin_kind_e spin;
    logic [4:0] mult;    // Level plus one, 1 to 16
    streak_t    streak;  // Streak before this event
  } award_req_t;

  // ====================================================================
  // Progression and scoring constants
  // ====================================================================
  localparam line_count_t LINES_PER_LEVEL  = 8'd10;
  localparam level_t      MAX_LEVEL        = 4'd15;
  localparam streak_t     STREAK_MAX       = 4'd15;
  localparam streak_t     STREAK_BONUS_CAP = 4'd5;
  localparam points_t     STREAK_STEP      = 16'd100;

  localparam frames_t DROP_FRAMES [16] = '{6'd40, 6'd37, 6'd34, 6'd30, 6'd26, 6'd21, 6'd15,
                                           6'd12, 6'd8, 6'd6, 6'd5, 6'd5, 6'd5, 6'd4, 6'd3, 6'd2};

  localparam points_t BASE_POINTS [5] = '{16'd0, 16'd40, 16'd100, 16'd300, 16'd1200};

  // Spin bonus per line count, scaled by the level multiplier later
  localparam points_t SPIN_BONUS [6][5] = '{
    '{16'd0, 16'd0,   16'd0,    16'd0,    16'd0},     // None
    '{16'd0, 16'd800, 16'd1200, 16'd1600, 16'd0},     // T
    '{16'd0, 16'd200, 16'd0,    16'd0,    16'd0},     // T mini
    '{16'd0, 16'd400, 16'd800,  16'd1200, 16'd0},     // S/Z
    '{16'd0, 16'd400, 16'd800,  16'd1200, 16'd0},     // J/L
    '{16'd0, 16'd400, 16'd800,  16'd0,    16'd1600}   // I
  };

endpackage

// File: hdl/clear_tally.sv
`timescale 1ns/1ps

module clear_tally (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          event_valid,
  input  tetris_score_pkg::clear_event_t event_in,
  output logic                          req_valid,
  output tetris_score_pkg::award_req_t  req,
  output tetris_score_pkg::line_count_t total_lines,
  output tetris_score_pkg::level_t      level,
  output tetris_score_pkg::frames_t     drop_frames,
  output tetris_score_pkg::streak_t     streak
);

  tetris_score_pkg::line_count_t level_raw;

  // ====================================================================
  // Level and gravity speed from the running line total
  // ====================================================================
  always_comb begin
    level_raw = total_lines / tetris_score_pkg::LINES_PER_LEVEL;
    if (level_raw > tetris_score_pkg::line_count_t'(tetris_score_pkg::MAX_LEVEL)) begin
      level = tetris_score_pkg::MAX_LEVEL;
    end else begin
      level = level_raw[3:0];
    end
    drop_frames = tetris_score_pkg::DROP_FRAMES[level];
  end

  // Totals and streak
  always_ff @(posedge clk) begin
    if (rst) begin
      total_lines <= '0;
      streak      <= '0;
    end else if (event_valid) begin
      total_lines <= total_lines + tetris_score_pkg::line_count_t'(event_in.lines);
      if (event_in.lines == 3'd0) begin
        streak <= '0;  // Chain broken
      end else if (streak < tetris_score_pkg::STREAK_MAX) begin
        streak <= streak + 4'd1;
      end
    end
  end

  // Award request carries the state as it stood before this event
  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= event_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (event_valid) begin
      req.lines  <= event_in.lines;
      req.spin   <= event_in.spin;
      req.mult   <= {1'b0, level} + 5'd1;
      req.streak <= streak;
    end
  end

  // Upstream never reports more than a four-line clear
  a_lines_range: assert property (
    @(posedge clk) disable iff (rst)
    event_valid |-> (event_in.lines <= 3'd4)
  );

endmodule

// File: hdl/points_calc.sv
`timescale 1ns/1ps

module points_calc (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         req_valid,
  input  tetris_score_pkg::award_req_t req,
  output logic                         pts_valid,
  output tetris_score_pkg::points_t    pts
);

  tetris_score_pkg::points_t mult_w;
  tetris_score_pkg::points_t base_total;
  tetris_score_pkg::points_t streak_bonus;
  tetris_score_pkg::points_t spin_bonus;
  tetris_score_pkg::points_t award_c;
  tetris_score_pkg::streak_t streak_capped;

  // ====================================================================
  // Award terms
  // ====================================================================
  always_comb begin
    mult_w     = tetris_score_pkg::points_t'(req.mult);
    base_total = tetris_score_pkg::BASE_POINTS[req.lines] * mult_w;

    // Bonus stops growing once the chain reaches the cap
    if (req.streak > tetris_score_pkg::STREAK_BONUS_CAP) begin
      streak_capped = tetris_score_pkg::STREAK_BONUS_CAP;
    end else begin
      streak_capped = req.streak;
    end
    streak_bonus = tetris_score_pkg::STREAK_STEP *
                   tetris_score_pkg::points_t'(streak_capped);  // Zero streak gives zero

    spin_bonus = tetris_score_pkg::SPIN_BONUS[req.spin][req.lines] * mult_w;

    if (req.lines == 3'd0) begin
      award_c = '0;  // No lines, no score
    end else begin
      award_c = base_total + streak_bonus + spin_bonus;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pts_valid <= 1'b0;
    end else begin
      pts_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      pts <= award_c;
    end
  end

  // Multiplier comes from the level, 0..15 maps to 1..16
  a_mult_range: assert property (
    @(posedge clk) disable iff (rst)
    req_valid |-> (req.mult >= 5'd1 && req.mult <= 5'd16)
  );

endmodule

// File: hdl/bcd_convert.sv
`timescale 1ns/1ps

module bcd_convert (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         pts_valid,
  input  tetris_score_pkg::points_t    pts,
  output logic                         bcd_valid,
  output tetris_score_pkg::bcd_award_t bcd
);

  logic [4*tetris_score_pkg::AWARD_DIGITS-1:0] shift_c;

  // Shift-and-add-3, MSB first
  always_comb begin
    shift_c = '0;
    for (int i = $bits(tetris_score_pkg::points_t) - 1; i >= 0; i--) begin
      for (int d = 0; d < tetris_score_pkg::AWARD_DIGITS; d++) begin
        if (shift_c[4*d +: 4] > 4'd4) begin
          shift_c[4*d +: 4] = shift_c[4*d +: 4] + 4'd3;
        end
      end
      shift_c = {shift_c[4*tetris_score_pkg::AWARD_DIGITS-2:0], pts[i]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bcd_valid <= 1'b0;
    end else begin
      bcd_valid <= pts_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pts_valid) begin
      bcd <= tetris_score_pkg::bcd_award_t'(shift_c);
    end
  end

  for (genvar d = 0; d < tetris_score_pkg::AWARD_DIGITS; d++) begin : g_digit_chk
    a_digit_dec: assert property (
      @(posedge clk) disable iff (rst)
      bcd_valid |-> (bcd[d] <= 4'd9)
    );
  end

endmodule

// File: hdl/score_accum.sv
`timescale 1ns/1ps

module score_accum (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         bcd_valid,
  input  tetris_score_pkg::bcd_award_t bcd,
  output tetris_score_pkg::score_bcd_t score,
  output logic                         score_strobe
);

  tetris_score_pkg::score_bcd_t award_ext;
  tetris_score_pkg::score_bcd_t sum_c;
  logic [4:0]                   dsum_c;
  logic                         carry_c;

  // ====================================================================
  // Decimal add, one digit at a time
  // ====================================================================
  always_comb begin
    award_ext = tetris_score_pkg::score_bcd_t'(bcd);  // Upper digits zero, carry only
    sum_c     = score;
    carry_c   = 1'b0;
    dsum_c    = '0;
    for (int d = 0; d < tetris_score_pkg::SCORE_DIGITS; d++) begin
      dsum_c = {1'b0, score[d]} + {1'b0, award_ext[d]} + {4'd0, carry_c};
      if (dsum_c > 5'd9) begin
        sum_c[d] = dsum_c[3:0] + 4'd6;  // Same as minus ten, mod 16
        carry_c  = 1'b1;
      end else begin
        sum_c[d] = dsum_c[3:0];
        carry_c  = 1'b0;
      end
    end
    // Final carry out is dropped so the score wraps past 99,999,999
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      score        <= '0;
      score_strobe <= 1'b0;
    end else begin
      score_strobe <= bcd_valid;  // Pulses even for a zero award
      if (bcd_valid) begin
        score <= sum_c;
      end
    end
  end

  for (genvar d = 0; d < tetris_score_pkg::SCORE_DIGITS; d++) begin : g_score_chk
    a_score_dec: assert property (
      @(posedge clk) disable iff (rst)
      score[d] <= 4'd9
    );
  end

endmodule

// File: hdl/score_pipeline.sv
`timescale 1ns/1ps

module score_pipeline (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          event_valid,
  input  tetris_score_pkg::clear_event_t event_in,
  output tetris_score_pkg::score_bcd_t  score,
  output logic                          score_strobe,
  output tetris_score_pkg::level_t      level,
  output tetris_score_pkg::line_count_t total_lines,
  output tetris_score_pkg::frames_t     drop_frames,
  output tetris_score_pkg::streak_t     streak
);

  // ====================================================================
  // Stage links, valid plus payload
  // ====================================================================
  logic                         req_valid;
  tetris_score_pkg::award_req_t req;
  logic                         pts_valid;
  tetris_score_pkg::points_t    pts;
  logic                         bcd_valid;
  tetris_score_pkg::bcd_award_t bcd;

  clear_tally u_tally (
    .clk(clk), .rst(rst),
    .event_valid(event_valid), .event_in(event_in),
    .req_valid(req_valid), .req(req),
    .total_lines(total_lines), .level(level),
    .drop_frames(drop_frames), .streak(streak)
  );

  points_calc u_points (  // Binary award
    .clk(clk), .rst(rst),
    .req_valid(req_valid), .req(req),
    .pts_valid(pts_valid), .pts(pts)
  );

  bcd_convert u_bcd (
    .clk(clk), .rst(rst),
    .pts_valid(pts_valid), .pts(pts),
    .bcd_valid(bcd_valid), .bcd(bcd)
  );

  score_accum u_accum (
    .clk(clk), .rst(rst),
    .bcd_valid(bcd_valid), .bcd(bcd),
    .score(score), .score_strobe(score_strobe)
  );

endmodule

// File: verif/score_pipeline_tb.sv
`timescale 1ns/1ps

module score_pipeline_tb;

  localparam int MAX_CASES = 64;
  localparam int CLK_HALF  = 10;  // 20 ns period

  logic                          clk;
  logic                          rst;
  logic                          event_valid;
  tetris_score_pkg::clear_event_t event_in;
  tetris_score_pkg::score_bcd_t  score;
  logic                          score_strobe;
  tetris_score_pkg::level_t      level;
  tetris_score_pkg::line_count_t total_lines;
  tetris_score_pkg::frames_t     drop_frames;
  tetris_score_pkg::streak_t     streak;

  // Case table with one entry per event
  logic [2:0]                    case_lines  [MAX_CASES];
  tetris_score_pkg::spin_kind_e  case_spin   [MAX_CASES];
  tetris_score_pkg::score_bcd_t  exp_score   [MAX_CASES];
  tetris_score_pkg::level_t      exp_level   [MAX_CASES];
  tetris_score_pkg::line_count_t exp_total   [MAX_CASES];
  tetris_score_pkg::frames_t     exp_frames  [MAX_CASES];
  tetris_score_pkg::streak_t     exp_streak  [MAX_CASES];
  int                            case_err    [MAX_CASES];

  int   n_cases;
  int   err_count;
  int   tally_idx;
  int   score_idx;
  logic tally_due    = 1'b0;
  logic cases_loaded = 1'b0;

  score_pipeline uut (
    .clk(clk), .rst(rst),
    .event_valid(event_valid), .event_in(event_in),
    .score(score), .score_strobe(score_strobe),
    .level(level), .total_lines(total_lines),
    .drop_frames(drop_frames), .streak(streak)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // ====================================================================
  // Compare tasks for each result type
  // ====================================================================
  task automatic note_error(input int idx);
    err_count = err_count + 1;
    if (idx >= 0) begin
      case_err[idx] = case_err[idx] + 1;
    end
  endtask

  task automatic score_compare(input int idx, input tetris_score_pkg::score_bcd_t exp_v,
                               input tetris_score_pkg::score_bcd_t act_v);
    if (act_v !== exp_v) begin
      $display("CHECK FAILED score: expected %h, actual %h (case %0d)", exp_v, act_v, idx);
      note_error(idx);
    end
  endtask

  task automatic level_compare(input int idx, input tetris_score_pkg::level_t exp_v,
                               input tetris_score_pkg::level_t act_v);
    if (act_v !== exp_v) begin
      $display("CHECK FAILED level: expected %h, actual %h (case %0d)", exp_v, act_v, idx);
      note_error(idx);
    end
  endtask

  task automatic lines_compare(input int idx, input tetris_score_pkg::line_count_t exp_v,
                               input tetris_score_pkg::line_count_t act_v);
    if (act_v !== exp_v) begin
      $display("CHECK FAILED total_lines: expected %h, actual %h (case %0d)",
               exp_v, act_v, idx);
      note_error(idx);
    end
  endtask

  task automatic frames_compare(input int idx, input tetris_score_pkg::frames_t exp_v,
                                input tetris_score_pkg::frames_t act_v);
    if (act_v !== exp_v) begin
      $display("CHECK FAILED drop_frames: expected %h, actual %h (case %0d)",
               exp_v, act_v, idx);
      note_error(idx);
    end
  endtask

  task automatic streak_compare(input int idx, input tetris_score_pkg::streak_t exp_v,
                                input tetris_score_pkg::streak_t act_v);
    if (act_v !== exp_v) begin
      $display("CHECK FAILED streak: expected %h, actual %h (case %0d)", exp_v, act_v, idx);
      note_error(idx);
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          lines_v;
    int          spin_v;
    int          level_v;
    int          total_v;
    int          frames_v;
    int          streak_v;
    logic [31:0] score_v;
    string       text;
    fd = $fopen("verif/score_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file verif/score_cases.txt");
    end else begin
      while (!$feof(fd) && n_cases < MAX_CASES) begin
        text = "";
        if ($fgets(text, fd) != 0 && text.len() > 0 && text[0] != "#" &&
            $sscanf(text, "%d %d %h %d %d %d %d", lines_v, spin_v, score_v,
                    level_v, total_v, frames_v, streak_v) == 7) begin
          case_lines[n_cases] = lines_v[2:0];
          case_spin[n_cases]  = tetris_score_pkg::spin_kind_e'(spin_v[2:0]);
          exp_score[n_cases]  = score_v;
          exp_level[n_cases]  = level_v[3:0];
          exp_total[n_cases]  = total_v[7:0];
          exp_frames[n_cases] = frames_v[5:0];
          exp_streak[n_cases] = streak_v[3:0];
          n_cases = n_cases + 1;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic final_report();
    int passed;
    int failed;
    passed = 0;
    failed = 0;
    for (int i = 0; i < n_cases; i++) begin
      if (case_err[i] == 0) begin
        passed = passed + 1;
      end else begin
        failed = failed + 1;
      end
    end
    if (n_cases == 0) begin
      $display("No cases were read from the case file");
      err_count = err_count + 1;
    end
    $display("Summary: %0d cases passed, %0d failed, %0d errors", passed, failed, err_count);
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // ====================================================================
  // Stimulus with back to back events
  // ====================================================================
  initial begin
    rst         = 1'b1;
    event_valid = 1'b0;
    event_in    = '0;
    n_cases     = 0;
    err_count   = 0;
    tally_idx   = 0;
    score_idx   = 0;
    for (int i = 0; i < MAX_CASES; i++) begin
      case_err[i] = 0;
    end
    load_cases();
    cases_loaded = 1'b1;
    repeat (3) @(posedge clk);
    #2 rst = 1'b0;

    @(negedge clk);  // Values straight out of reset
    score_compare(-1, '0, score);
    level_compare(-1, 4'd0, level);
    lines_compare(-1, 8'd0, total_lines);
    frames_compare(-1, 6'd40, drop_frames);
    streak_compare(-1, 4'd0, streak);

    for (int i = 0; i < n_cases; i++) begin
      @(posedge clk);
      #2;
      event_valid    = 1'b1;
      event_in.lines = case_lines[i];
      event_in.spin  = case_spin[i];
    end
    @(posedge clk);
    #2;
    event_valid = 1'b0;
    event_in    = '0;

    wait (score_idx == n_cases);
    repeat (4) @(posedge clk);  // Room for a stray strobe to show up
    final_report();
  end

  always @(posedge clk) begin
    tally_due <= event_valid && !rst;  // Event sampled on this edge
  end

  // Responses sampled mid-cycle on the falling edge
  always @(negedge clk) begin
    if (tally_due) begin
      if (tally_idx < n_cases) begin
        level_compare(tally_idx, exp_level[tally_idx], level);
        lines_compare(tally_idx, exp_total[tally_idx], total_lines);
        frames_compare(tally_idx, exp_frames[tally_idx], drop_frames);
        streak_compare(tally_idx, exp_streak[tally_idx], streak);
      end
      tally_idx = tally_idx + 1;
    end
    if (score_strobe) begin
      if (score_idx >= n_cases) begin
        $display("Score strobe arrived with no event left to score");
        note_error(-1);
      end else begin
        score_compare(score_idx, exp_score[score_idx], score);
        $display("case %0d: lines %0d spin %s score %h %s", score_idx,
                 case_lines[score_idx], case_spin[score_idx].name(), score,
                 (case_err[score_idx] == 0) ? "ok" : "mismatch");
        score_idx = score_idx + 1;
      end
    end
  end

  // Watchdog sized from the number of cases
  initial begin
    wait (cases_loaded);
    repeat (n_cases * 8 + 20) @(posedge clk);
    $display("Timeout with %0d of %0d scores seen", score_idx, n_cases);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: verif/score_cases.txt
# lines spin(0 none 1 T 2 T-mini 3 S/Z 4 J/L 5 I) score(BCD hex) level total_lines drop_frames
# streak; values after the event, score after its award is added
1 0 00000040 0  1 40  1
2 0 00000240 0  3 40  2
3 0 00000740 0  6 40  3
0 0 00000740 0  6 40  0
4 0 00001940 1 10 37  1
1 1 00003720 1 11 37  2
0 1 00003720 1 11 37  0
1 2 00004200 1 12 37  1
2 3 00006100 1 14 37  2
3 4 00009300 1 17 37  3
4 5 00015200 2 21 34  4
2 1 00019500 2 23 34  5
3 1 00025700 2 26 34  6
1 5 00027520 2 27 34  7
4 0 00031620 3 31 30  8
4 0 00036920 3 35 30  9
4 0 00042220 3 39 30 10
4 0 00047520 4 43 26 11
4 0 00054020 4 47 26 12
4 0 00060520 5 51 21 13
4 0 00068220 5 55 21 14
4 0 00075920 5 59 21 15
4 0 00083620 6 63 15 15
4 0 00092520 6 67 15 15
4 0 00101420 7 71 12 15
4 0 00111520 7 75 12 15
0 0 00111520 7 75 12  0
4 1 00121120 7 79 12  1
1 0 00121540 8 80  8  2

// File: src.f
hdl/tetris_score_pkg.sv
hdl/clear_tally.sv
hdl/points_calc.sv
hdl/bcd_convert.sv
hdl/score_accum.sv
hdl/score_pipeline.sv
verif/score_pipeline_tb.sv

// File: Bender.yml
package:
  name: tetris_score

sources:
  - hdl/tetris_score_pkg.sv
  - hdl/clear_tally.sv
  - hdl/points_calc.sv
  - hdl/bcd_convert.sv
  - hdl/score_accum.sv
  - hdl/score_pipeline.sv
  - target: test
    files:
      - verif/score_pipeline_tb.sv
